/* design/dcache.sv */
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  cpu_req_t    cpu,
    input  logic        halt,
    input  logic        dwait,
    input  word_t       dload,
    output logic        dhit,
    output word_t       dmemload,
    output logic        flushed,
    output mem_req_t    mem
);

    logic [IDX_W-1:0] rd_idx;                           // shared by both ways
    logic [TAG_W-1:0] rd_tag;
    way_wr_t          wr0;
    way_wr_t          wr1;
    logic             hit0;
    logic             hit1;
    cache_line_t      line0;
    cache_line_t      line1;

    ////////////////////////////////////////////////////////////
    // the two ways
    ////////////////////////////////////////////////////////////
    dcache_way u_way0 (
        .CLK    (CLK),
        .nRST   (nRST),
        .rd_idx (rd_idx),
        .rd_tag (rd_tag),
        .wr     (wr0),
        .hit    (hit0),
        .line   (line0)
    );

    dcache_way u_way1 (
        .CLK    (CLK),
        .nRST   (nRST),
        .rd_idx (rd_idx),
        .rd_tag (rd_tag),
        .wr     (wr1),
        .hit    (hit1),
        .line   (line1)
    );

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////
    dcache_ctrl u_ctrl (
        .CLK      (CLK),
        .nRST     (nRST),
        .cpu      (cpu),
        .halt     (halt),
        .hit0     (hit0),
        .hit1     (hit1),
        .line0    (line0),
        .line1    (line1),
        .dwait    (dwait),
        .dload    (dload),
        .rd_idx   (rd_idx),
        .rd_tag   (rd_tag),
        .wr0      (wr0),
        .wr1      (wr1),
        .mem      (mem),
        .dhit     (dhit),
        .dmemload (dmemload),
        .flushed  (flushed)
    );

endmodule

/* design/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  cpu_req_t          cpu,
    input  logic              halt,
    input  logic              hit0,
    input  logic              hit1,
    input  cache_line_t       line0,
    input  cache_line_t       line1,
    input  logic              dwait,
    input  word_t             dload,
    output logic [IDX_W-1:0]  rd_idx,
    output logic [TAG_W-1:0]  rd_tag,
    output way_wr_t           wr0,
    output way_wr_t           wr1,
    output mem_req_t          mem,
    output logic              dhit,
    output word_t             dmemload,
    output logic              flushed
);

    typedef enum logic [2:0] {
        IDLE,
        WB_LO,
        WB_HI,
        FILL_LO,
        FILL_HI,
        FLUSH_LO,
        FLUSH_HI,
        DONE
    } state_t;

    state_t           state;
    state_t           next_state;
    logic [SETS-1:0]  lru_q;                            // victim way per set
    logic [IDX_W:0]   flush_cnt;                        // {set, way}
    logic [IDX_W:0]   flush_cnt_d;
    logic [IDX_W-1:0] flush_set;
    logic             slot_way;
    logic             req;
    logic             any_hit;
    logic             victim_way;
    logic             wr_way;                           // which way gets wr_cmd
    cache_line_t      victim_line;
    cache_line_t      slot_line;
    cache_line_t      hit_line;
    way_wr_t          wr_cmd;

    ////////////////////////////////////////////////////////////
    // lookup and hit path
    ////////////////////////////////////////////////////////////
    assign req     = cpu.ren || cpu.wen;
    assign any_hit = hit0 || hit1;
    assign dhit    = (state == IDLE) && req && any_hit;

    assign hit_line = hit1 ? line1 : line0;             // select on the way that hit
    assign dmemload = cpu.addr.blkoff ? hit_line.word1 : hit_line.word0;

    assign flush_set = flush_cnt[IDX_W:1];
    assign slot_way  = flush_cnt[0];

    // both ways always look at the same set
    assign rd_idx = (state == FLUSH_LO || state == FLUSH_HI) ? flush_set : cpu.addr.idx;
    assign rd_tag = cpu.addr.tag;

    assign victim_way  = lru_q[cpu.addr.idx];
    assign victim_line = victim_way ? line1 : line0;
    assign slot_line   = slot_way ? line1 : line0;

    assign flushed = (state == DONE);                   // sticky until reset

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
            lru_q     <= '0;                            // way 0 goes first
        end else begin
            state     <= next_state;
            flush_cnt <= flush_cnt_d;
            if (dhit) begin
                lru_q[cpu.addr.idx] <= hit0;            // the other way becomes victim
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and way commands
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_state  = state;
        flush_cnt_d = flush_cnt;
        wr_way      = victim_way;
        wr_cmd      = '{op: OP_NONE, idx: cpu.addr.idx, tag: cpu.addr.tag,
                        blkoff: cpu.addr.blkoff, data: cpu.store};
        case (state)
            IDLE: begin
                if (req && any_hit) begin
                    if (cpu.wen) begin
                        wr_cmd.op = OP_STORE;
                        wr_way    = hit1;
                    end
                end else if (req) begin
                    next_state = victim_line.dirty ? WB_LO : FILL_LO;
                end else if (halt) begin
                    next_state  = FLUSH_LO;
                    flush_cnt_d = '0;
                end
            end
            WB_LO: begin
                if (!dwait) begin
                    next_state = WB_HI;
                end
            end
            WB_HI: begin
                if (!dwait) begin
                    wr_cmd.op  = OP_CLEAN;              // victim now matches memory
                    next_state = FILL_LO;
                end
            end
            FILL_LO: begin
                if (!dwait) begin
                    wr_cmd.op   = OP_FILL_LO;
                    wr_cmd.data = dload;
                    next_state  = FILL_HI;
                end
            end
            FILL_HI: begin
                if (!dwait) begin
                    wr_cmd.op   = OP_FILL_HI;
                    wr_cmd.data = dload;
                    next_state  = IDLE;                 // request hits next cycle
                end
            end
            FLUSH_LO: begin
                wr_cmd.idx = flush_set;
                wr_way     = slot_way;
                if (slot_line.dirty) begin
                    if (!dwait) begin
                        next_state = FLUSH_HI;
                    end
                end else begin
                    // a clean or empty slot is dropped in one cycle
                    wr_cmd.op   = OP_INVAL;
                    flush_cnt_d = flush_cnt + 1'b1;
                    if (&flush_cnt) begin
                        next_state = DONE;
                    end
                end
            end
            FLUSH_HI: begin
                wr_cmd.idx = flush_set;
                wr_way     = slot_way;
                if (!dwait) begin
                    wr_cmd.op   = OP_INVAL;
                    flush_cnt_d = flush_cnt + 1'b1;
                    next_state  = (&flush_cnt) ? DONE : FLUSH_LO;
                end
            end
            default: begin
            end
        endcase
    end

    // steer the command to one way while the other idles
    always_comb begin
        wr0 = wr_cmd;
        wr1 = wr_cmd;
        if (wr_way) begin
            wr0.op = OP_NONE;
        end else begin
            wr1.op = OP_NONE;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////
    always_comb begin
        mem = '0;
        case (state)
            WB_LO, WB_HI: begin
                mem.wen   = 1'b1;
                mem.addr  = {victim_line.tag, cpu.addr.idx, (state == WB_HI), 2'b00};
                mem.store = (state == WB_HI) ? victim_line.word1 : victim_line.word0;
            end
            FILL_LO, FILL_HI: begin
                mem.ren  = 1'b1;
                mem.addr = {cpu.addr.tag, cpu.addr.idx, (state == FILL_HI), 2'b00};
            end
            FLUSH_LO: begin
                mem.wen   = slot_line.dirty;            // nothing to write otherwise
                mem.addr  = {slot_line.tag, flush_set, 1'b0, 2'b00};
                mem.store = slot_line.word0;
            end
            FLUSH_HI: begin
                mem.wen   = 1'b1;
                mem.addr  = {slot_line.tag, flush_set, 1'b1, 2'b00};
                mem.store = slot_line.word1;
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a request the memory is still waiting on stays put until a word moves
    a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem.ren || mem.wen) && dwait) |=> $stable(mem))
        else $error("memory request changed while the memory was waiting");

    // a block may live in only one way of a set
    a_one_hit: assert property (@(posedge CLK) disable iff (!nRST)
        !(hit0 && hit1))
        else $error("both ways hit the same address");

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////
    localparam int WORD_W = 32;                       // data and address width
    localparam int IDX_W  = 3;                        // set index bits
    localparam int SETS   = 8;                        // 2**IDX_W
    localparam int TAG_W  = WORD_W - IDX_W - 3;       // minus block and byte offset

    typedef logic [WORD_W-1:0] word_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;                     // word within block
        logic [1:0]       bytoff;
    } daddr_t;

    // one block as read out of a way
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
        word_t            word0;
        word_t            word1;
    } cache_line_t;

    ////////////////////////////////////////////////////////////
    // way commands
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_STORE   = 3'd1,                            // one word, sets dirty
        OP_FILL_LO = 3'd2,                            // word0 only
        OP_FILL_HI = 3'd3,                            // word1, tag, valid, clean
        OP_CLEAN   = 3'd4,
        OP_INVAL   = 3'd5
    } way_op_t;

    typedef struct packed {
        way_op_t          op;
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic             blkoff;
        word_t            data;
    } way_wr_t;

    ////////////////////////////////////////////////////////////
    // external requests
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic   ren;
        logic   wen;
        daddr_t addr;
        word_t  store;
    } cpu_req_t;

    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;                                  // always word aligned
        word_t store;
    } mem_req_t;

endpackage

/* design/dcache_way.sv */
`timescale 1ns/1ps

module dcache_way import dcache_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic [IDX_W-1:0]  rd_idx,
    input  logic [TAG_W-1:0]  rd_tag,
    input  way_wr_t           wr,
    output logic              hit,
    output cache_line_t       line
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    logic [TAG_W-1:0] tag_q   [SETS];
    word_t            word0_q [SETS];
    word_t            word1_q [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////
    always_comb begin
        line.tag   = tag_q[rd_idx];
        line.valid = valid_q[rd_idx];
        line.dirty = dirty_q[rd_idx];
        line.word0 = word0_q[rd_idx];
        line.word1 = word1_q[rd_idx];
    end

    assign hit = line.valid && (line.tag == rd_tag);   // invalid lines never hit

    ////////////////////////////////////////////////////////////
    // status bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;                              // cold cache
            dirty_q <= '0;
        end else begin
            case (wr.op)
                OP_STORE: begin
                    dirty_q[wr.idx] <= 1'b1;
                end
                OP_FILL_HI: begin
                    valid_q[wr.idx] <= 1'b1;            // block complete
                    dirty_q[wr.idx] <= 1'b0;
                end
                OP_CLEAN: begin
                    dirty_q[wr.idx] <= 1'b0;            // after write-back
                end
                OP_INVAL: begin
                    valid_q[wr.idx] <= 1'b0;
                    dirty_q[wr.idx] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // tag and data
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        case (wr.op)
            OP_STORE: begin
                if (wr.blkoff) begin
                    word1_q[wr.idx] <= wr.data;
                end else begin
                    word0_q[wr.idx] <= wr.data;
                end
            end
            OP_FILL_LO: begin
                word0_q[wr.idx] <= wr.data;             // first half of refill
            end
            OP_FILL_HI: begin
                word1_q[wr.idx] <= wr.data;
                tag_q[wr.idx]   <= wr.tag;              // new owner of the slot
            end
            default: begin
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // the controller may only store into a block this way just reported as a hit
    a_store_on_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (wr.op == OP_STORE) |-> (valid_q[wr.idx] && (tag_q[wr.idx] == wr.tag)))
        else $error("store issued to a line that does not hold the tag");

    // a refill must never overwrite modified data that was not written back
    a_fill_clean: assert property (@(posedge CLK) disable iff (!nRST)
        (wr.op == OP_FILL_LO) |-> !dirty_q[wr.idx])
        else $error("refill started on a dirty line");

endmodule

/* files.f */
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_ctrl.sv
design/dcache.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

/* tb/dcache_mem_model.sv */
`timescale 1ns/1ps

module dcache_mem_model import dcache_pkg::*; (
    input  logic     CLK,
    input  mem_req_t mem,
    output logic     dwait,
    output word_t    dload
);

    localparam int WAIT_CYCLES = 2;                     // dwait high cycles per request

    word_t words    [256];
    word_t log_addr [512];                              // completed writes, in order
    word_t log_data [512];
    int    log_count;
    int    held;                                        // cycles the request has waited
    logic  req;

    assign req = mem.ren || mem.wen;

    initial begin
        for (int w = 0; w < 256; w++) begin
            words[w] = {w[7:0] ^ 8'h5a, 8'hc3, ~w[7:0], w[7:0]};
        end
        log_count = 0;
        held      = 0;
        dwait     = 1'b0;
        dload     = '0;
    end

    // outputs change on the falling edge, away from the sampling edge
    always @(negedge CLK) begin
        dwait <= req && (held < WAIT_CYCLES);
        if (mem.ren) begin
            dload <= words[mem.addr[9:2]];
        end
    end

    ////////////////////////////////////////////////////////////
    // one word moves at a rising edge that sees dwait low
    ////////////////////////////////////////////////////////////
    always @(posedge CLK) begin
        if (!req) begin
            held <= 0;
        end else if (!dwait) begin
            held <= 0;                                  // next request waits again
            if (mem.wen) begin
                words[mem.addr[9:2]] <= mem.store;
                log_addr[log_count]  <= mem.addr;
                log_data[log_count]  <= mem.store;
                log_count            <= log_count + 1;
            end
        end else begin
            held <= held + 1;
        end
    end

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;               // bound on the whole run

    logic     CLK;
    logic     nRST;
    cpu_req_t cpu;
    logic     halt;
    logic     dwait;
    word_t    dload;
    logic     dhit;
    word_t    dmemload;
    logic     flushed;
    mem_req_t mem;
    word_t    exp_mem [256];                            // expected memory contents
    int       cycle_cnt = 0;
    integer   seed;

    dcache u_dcache (.CLK(CLK), .nRST(nRST), .cpu(cpu), .halt(halt), .dwait(dwait),
        .dload(dload), .dhit(dhit), .dmemload(dmemload), .flushed(flushed), .mem(mem));

    dcache_mem_model u_mem (.CLK(CLK), .mem(mem), .dwait(dwait), .dload(dload));

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR timeout: tests still running after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $fatal(1, "simulation stopped");
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic word_t fill_pattern(int unsigned w);
        logic [7:0] b;
        b = w[7:0];
        return {b ^ 8'h5a, 8'hc3, ~b, b};
    endfunction

    function automatic word_t make_addr(int tag, int idx, int off);
        daddr_t a;
        a.tag    = tag[TAG_W-1:0];
        a.idx    = idx[IDX_W-1:0];
        a.blkoff = off[0];
        a.bytoff = 2'b00;
        return a;
    endfunction

    task automatic compare_word(string test, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", test, expected, actual);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic require_true(string test, logic cond, string what);
        assert (cond) else begin
            $display("ERROR %s: %s", test, what);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apply_reset();
        cpu  = '0;
        halt = 1'b0;
        nRST = 1'b0;
        repeat (5) @(negedge CLK);
        nRST = 1'b1;
    endtask

    // starts and ends on a falling edge and holds the request until dhit
    task automatic access(logic write, word_t addr, word_t data,
                          output word_t rdata, output int waited);
        waited    = 0;
        cpu.ren   = !write;
        cpu.wen   = write;
        cpu.addr  = addr;
        cpu.store = data;
        #1;
        while (!dhit) begin
            @(negedge CLK);
            #1;
            waited++;
        end
        rdata = dmemload;
        @(negedge CLK);                                 // store lands at the edge in between
        cpu = '0;
    endtask

    task automatic load_and_check(string test, word_t addr, logic expect_hit);
        word_t rdata;
        int    waited;
        access(1'b0, addr, '0, rdata, waited);
        compare_word(test, exp_mem[addr[9:2]], rdata);
        require_true(test, (waited == 0) == expect_hit, "load hit or missed unexpectedly");
    endtask

    task automatic store_word(string test, word_t addr, word_t data, logic expect_hit);
        word_t rdata;
        int    waited;
        access(1'b1, addr, data, rdata, waited);
        exp_mem[addr[9:2]] = data;
        require_true(test, (waited == 0) == expect_hit, "store hit or missed unexpectedly");
    endtask

    task automatic flush_and_wait();
        halt = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        halt = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic read_miss_then_hit();
        word_t a;
        a = make_addr(1, 2, 0);
        load_and_check("read_miss_then_hit", a, 1'b0);
        load_and_check("read_miss_then_hit", a, 1'b1);
        load_and_check("read_miss_then_hit", a + 4, 1'b1);  // other word of the block
    endtask

    task automatic store_hit();
        word_t a;
        word_t data;
        int    base;
        a    = make_addr(1, 2, 1);
        data = $random(seed);
        base = u_mem.log_count;
        store_word("store_hit", a, data, 1'b1);
        require_true("store_hit", u_mem.log_count == base, "store hit was written to memory");
        compare_word("store_hit", fill_pattern(a[9:2]), u_mem.words[a[9:2]]);
        load_and_check("store_hit", a, 1'b1);
    endtask

    task automatic lru_replacement();
        load_and_check("lru_replacement", make_addr(2, 5, 0), 1'b0);  // A
        load_and_check("lru_replacement", make_addr(3, 5, 0), 1'b0);  // B
        load_and_check("lru_replacement", make_addr(2, 5, 0), 1'b1);  // A again
        load_and_check("lru_replacement", make_addr(4, 5, 0), 1'b0);  // C evicts B
        load_and_check("lru_replacement", make_addr(2, 5, 0), 1'b1);
        load_and_check("lru_replacement", make_addr(3, 5, 0), 1'b0);
    endtask

    task automatic dirty_eviction();
        word_t d;
        word_t data;
        int    base;
        d    = make_addr(5, 6, 1);
        data = $random(seed);
        store_word("dirty_eviction", d, data, 1'b0);
        load_and_check("dirty_eviction", make_addr(6, 6, 0), 1'b0);
        base = u_mem.log_count;
        load_and_check("dirty_eviction", make_addr(7, 6, 0), 1'b0);  // victim is the stored block
        require_true("dirty_eviction", u_mem.log_count == base + 2,
                     "write-back did not write exactly two words");
        compare_word("dirty_eviction", d - 4, u_mem.log_addr[base]);
        compare_word("dirty_eviction", exp_mem[d[9:2] - 1], u_mem.log_data[base]);
        compare_word("dirty_eviction", d, u_mem.log_addr[base + 1]);
        compare_word("dirty_eviction", data, u_mem.log_data[base + 1]);
        load_and_check("dirty_eviction", d, 1'b0);
    endtask

    task automatic flush_all();
        logic [SETS-1:0] stored;                        // sets holding a dirty tag 8 block
        word_t           a;
        word_t           data;
        int              r;
        int              base;
        flush_and_wait();                               // drains whatever earlier tests left
        for (int w = 0; w < 256; w++) begin
            compare_word("flush_all", exp_mem[w], u_mem.words[w]);
        end
        apply_reset();
        for (int i = 0; i < SETS; i++) begin
            load_and_check("flush_all", make_addr(9, i, 0), 1'b0);  // clean blocks
        end
        stored = '0;
        for (int n = 0; n < 12; n++) begin
            r    = $random(seed);
            data = $random(seed);
            a    = make_addr(8, r[2:0], r[3]);
            store_word("flush_all", a, data, stored[r[2:0]]);
            stored[r[2:0]] = 1'b1;
        end
        base = u_mem.log_count;
        flush_and_wait();
        require_true("flush_all", u_mem.log_count - base == 2 * $countones(stored),
                     "flush wrote a different number of words than the dirty blocks hold");
        for (int i = base; i < u_mem.log_count; i++) begin
            a = u_mem.log_addr[i];
            require_true("flush_all", (a[31:6] == 8) && stored[a[5:3]],
                         "flush wrote back a clean block");
        end
        for (int w = 0; w < 256; w++) begin
            compare_word("flush_all", exp_mem[w], u_mem.words[w]);
        end
        apply_reset();
        load_and_check("flush_all", a, 1'b0);           // refill from flushed memory
    endtask

    initial begin
        seed = 32'ha207_c04d;
        for (int w = 0; w < 256; w++) begin
            exp_mem[w] = fill_pattern(w);
        end
        apply_reset();
        read_miss_then_hit();
        store_hit();
        lru_replacement();
        dirty_eviction();
        flush_all();
        $display("All tests passed");
        $finish;
    end

endmodule
